/* hdl/bcrypt_host_pkg.sv */
// sizes, address region and command enums, bus and memory request structs
`default_nettype none

package bcrypt_host_pkg;

	// word width of bus data and of every memory word
	localparam int data_width = 32;
	// hashing cores behind this controller
	localparam int num_cores = 4;
	// per-core memory depths in words
	localparam int other_depth = 64;
	localparam int s_depth = 1024;

	// core number field, same width as the address fields
	typedef logic [6:0] core_idx_t;
	// word offset inside one region
	typedef logic [9:0] word_addr_t;

	// one-hot chip select from the bus
	typedef enum logic [2:0] {
		region_ctrl  = 3'd1,
		region_other = 3'd2,
		region_s     = 3'd4
	} region_e;

	// values of control word 0
	typedef enum logic [31:0] {
		cmd_idle = 32'd0,
		cmd_run  = 32'd1
	} cmd_e;

	// control word 1 once every core has finished
	localparam logic [data_width-1:0] status_done = 32'hFF;

	// one bus transfer as seen by the decoder
	typedef struct packed {
		region_e               region;
		logic                  rnw;
		logic [31:0]           addr;
		logic [data_width-1:0] wdata;
	} bus_req_t;

	// request into a memory or the control window
	typedef struct packed {
		logic                  we;
		word_addr_t            addr;
		logic [data_width-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

/* hdl/word_ram.sv */
// single-port synchronous word memory with registered read data
`default_nettype none
`timescale 1ns/10ps

module word_ram #(
	parameter int depth = 64
) (
	input  wire                                      Bus2IP_Clk,
	input  bcrypt_host_pkg::mem_req_t                req_i,
	output logic [bcrypt_host_pkg::data_width-1:0]   rdata_o
);

	import bcrypt_host_pkg::*;

	// word storage
	logic [data_width-1:0] mem [depth];
	// only the low bits address a shallow memory
	logic [$clog2(depth)-1:0] idx;

	assign idx = req_i.addr[$clog2(depth)-1:0];

	always_ff @(posedge Bus2IP_Clk) begin
		// full-word write on the enable
		if (req_i.we) begin
			mem[idx] <= req_i.wdata;
		end
		// addressed word read every cycle
		// a write returns the old data
		rdata_o <= mem[idx];
	end

endmodule

`default_nettype wire

/* hdl/core_mem_bank.sv */
// one core's other and S memories, host writes blocked while the core runs
`default_nettype none
`timescale 1ns/10ps

module core_mem_bank (
	input  wire                                      Bus2IP_Clk,
	input  wire                                      running_i,
	input  bcrypt_host_pkg::mem_req_t                other_req_i,
	input  bcrypt_host_pkg::mem_req_t                s_req_i,
	output logic [bcrypt_host_pkg::data_width-1:0]   other_rdata_o,
	output logic [bcrypt_host_pkg::data_width-1:0]   s_rdata_o
);

	import bcrypt_host_pkg::*;

	// requests after the running-core mask
	mem_req_t other_req;
	mem_req_t s_req;

	always_comb begin
		other_req = other_req_i;
		s_req = s_req_i;
		// engine owns the memories while running
		// reads still pass, only the write enable drops
		other_req.we = other_req_i.we & ~running_i;
		s_req.we = s_req_i.we & ~running_i;
	end

	// 64-word other memory
	word_ram #(
		.depth(other_depth)
	) u_other_ram (
		.Bus2IP_Clk(Bus2IP_Clk),
		.req_i     (other_req),
		.rdata_o   (other_rdata_o)
	);

	// 1024-word S-box memory
	word_ram #(
		.depth(s_depth)
	) u_s_ram (
		.Bus2IP_Clk(Bus2IP_Clk),
		.req_i     (s_req),
		.rdata_o   (s_rdata_o)
	);

endmodule

`default_nettype wire

/* hdl/job_control.sv */
// control window, run command, per-core start and done tracking, completion status
`default_nettype none
`timescale 1ns/10ps

module job_control (
	input  wire                                          Bus2IP_Clk,
	input  wire                                          arst_n_i,
	input  bcrypt_host_pkg::mem_req_t                    req_i,
	input  wire  [bcrypt_host_pkg::num_cores-1:0]        core_done_i,
	output logic [bcrypt_host_pkg::data_width-1:0]       rdata_o,
	output logic [bcrypt_host_pkg::num_cores-1:0]        core_start_o
);

	import bcrypt_host_pkg::*;

	// word 0, the command
	cmd_e                  ctrl_cmd_q;
	// word 1, completion status
	logic [data_width-1:0] ctrl_status_q;
	// one flag per core, set by its done pulse
	logic [num_cores-1:0]  done_q;
	logic                  wr_cmd;
	logic                  all_done;

	assign wr_cmd = req_i.we && (req_i.addr == word_addr_t'(0));
	assign all_done = &done_q;

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_cmd_q <= cmd_idle;
			ctrl_status_q <= '0;
			done_q <= '0;
			core_start_o <= '0;
		end else begin
			// host write to word 0, status starts over
			if (wr_cmd) begin
				ctrl_cmd_q <= cmd_e'(req_i.wdata);
				ctrl_status_q <= '0;
			end
			// every core finished, back to idle and flag it
			// takes priority over a host write in the same cycle
			if (all_done) begin
				ctrl_cmd_q <= cmd_idle;
				ctrl_status_q <= status_done;
			end
			// done flags collect pulses, idle clears them all
			if (ctrl_cmd_q == cmd_idle) begin
				done_q <= '0;
			end else begin
				done_q <= done_q | core_done_i;
			end
			// start follows run and not yet done, one cycle later
			if (ctrl_cmd_q == cmd_run) begin
				core_start_o <= ~done_q;
			end else begin
				core_start_o <= '0;
			end
		end
	end

	// read word one cycle after the address
	always_ff @(posedge Bus2IP_Clk) begin
		if (wr_cmd) begin
			// just-written command comes straight back
			rdata_o <= req_i.wdata;
		end else begin
			case (req_i.addr)
				word_addr_t'(0): rdata_o <= ctrl_cmd_q;
				word_addr_t'(1): rdata_o <= ctrl_status_q;
				default:         rdata_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/bus_decode.sv */
// region and core decode, per-core memory requests, read return select, bus acknowledges
`default_nettype none
`timescale 1ns/10ps

module bus_decode (
	input  wire                                        Bus2IP_Clk,
	input  wire                                        arst_n_i,
	input  bcrypt_host_pkg::bus_req_t                  req_i,
	input  wire                                        rdce_i,
	input  wire                                        wrce_i,
	input  wire  [bcrypt_host_pkg::data_width-1:0]     ctrl_rdata_i,
	input  wire  [bcrypt_host_pkg::data_width-1:0]     other_rdata_i [bcrypt_host_pkg::num_cores],
	input  wire  [bcrypt_host_pkg::data_width-1:0]     s_rdata_i [bcrypt_host_pkg::num_cores],
	output bcrypt_host_pkg::mem_req_t                  ctrl_req_o,
	output bcrypt_host_pkg::mem_req_t                  other_req_o [bcrypt_host_pkg::num_cores],
	output bcrypt_host_pkg::mem_req_t                  s_req_o [bcrypt_host_pkg::num_cores],
	output logic [bcrypt_host_pkg::data_width-1:0]     rdata_o,
	output logic                                       rdack_o,
	output logic                                       wrack_o
);

	import bcrypt_host_pkg::*;

	// fields split out of the address
	core_idx_t             core;
	word_addr_t            word;
	logic                  wr;
	// rdce history for the edge detect
	logic                  rdce_q;
	logic                  rdack_q;
	// what was addressed on the previous cycle
	region_e               sel_region_q;
	core_idx_t             sel_core_q;
	logic [data_width-1:0] rd_word;

	// address split by region
	always_comb begin
		core = '0;
		word = '0;
		case (req_i.region)
			region_ctrl: begin
				word = req_i.addr[11:2];
			end
			region_other: begin
				core = req_i.addr[14:8];
				word = {4'd0, req_i.addr[7:2]};
			end
			region_s: begin
				core = req_i.addr[18:12];
				word = req_i.addr[11:2];
			end
			default: begin
				core = '0;
				word = '0;
			end
		endcase
	end

	// write only while the write enable is up
	assign wr = wrce_i & ~req_i.rnw;

	// address and data go everywhere, enable only to the target
	always_comb begin
		ctrl_req_o.we = wr && (req_i.region == region_ctrl);
		ctrl_req_o.addr = word;
		ctrl_req_o.wdata = req_i.wdata;
		for (int c = 0; c < num_cores; c++) begin
			other_req_o[c].we = wr && (req_i.region == region_other) &&
				(core == core_idx_t'(c));
			other_req_o[c].addr = word;
			other_req_o[c].wdata = req_i.wdata;
			s_req_o[c].we = wr && (req_i.region == region_s) &&
				(core == core_idx_t'(c));
			s_req_o[c].addr = word;
			s_req_o[c].wdata = req_i.wdata;
		end
	end

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdce_q <= 1'b0;
			rdack_q <= 1'b0;
			sel_region_q <= region_ctrl;
			sel_core_q <= '0;
		end else begin
			rdce_q <= rdce_i;
			// one pulse on the rising edge of rdce
			rdack_q <= rdce_i & ~rdce_q;
			// lines up with the registered memory output
			sel_region_q <= req_i.region;
			sel_core_q <= core;
		end
	end

	// pick the returned word, unknown cores read 0
	always_comb begin
		rd_word = '0;
		case (sel_region_q)
			region_ctrl: begin
				rd_word = ctrl_rdata_i;
			end
			region_other: begin
				for (int c = 0; c < num_cores; c++) begin
					if (sel_core_q == core_idx_t'(c)) begin
						rd_word = other_rdata_i[c];
					end
				end
			end
			region_s: begin
				for (int c = 0; c < num_cores; c++) begin
					if (sel_core_q == core_idx_t'(c)) begin
						rd_word = s_rdata_i[c];
					end
				end
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	// data only while the ack is high
	assign rdata_o = rdack_q ? rd_word : '0;
	assign rdack_o = rdack_q;
	// write ack same cycle as the enable
	assign wrack_o = wrce_i;

endmodule

`default_nettype wire

/* hdl/bcrypt_host_top.sv */
// top level, bus decoder, job control and one memory bank per core
`default_nettype none
`timescale 1ns/10ps

module bcrypt_host_top (
	input  wire                                        Bus2IP_Clk,
	input  wire                                        arst_n_i,
	input  bcrypt_host_pkg::region_e                   bus2ip_cs_i,
	input  wire                                        bus2ip_rnw_i,
	input  wire  [31:0]                                bus2ip_addr_i,
	input  wire  [bcrypt_host_pkg::data_width-1:0]     bus2ip_data_i,
	input  wire                                        bus2ip_rdce_i,
	input  wire                                        bus2ip_wrce_i,
	output logic [bcrypt_host_pkg::data_width-1:0]     ip2bus_data_o,
	output logic                                       ip2bus_rdack_o,
	output logic                                       ip2bus_wrack_o,
	output logic [bcrypt_host_pkg::num_cores-1:0]      core_start_o,
	input  wire  [bcrypt_host_pkg::num_cores-1:0]      core_done_i
);

	import bcrypt_host_pkg::*;

	// bus inputs as one transfer
	bus_req_t              bus_req;
	mem_req_t              ctrl_req;
	mem_req_t              other_req [num_cores];
	mem_req_t              s_req [num_cores];
	logic [data_width-1:0] ctrl_rdata;
	logic [data_width-1:0] other_rdata [num_cores];
	logic [data_width-1:0] s_rdata [num_cores];

	assign bus_req = '{
		region: bus2ip_cs_i,
		rnw:    bus2ip_rnw_i,
		addr:   bus2ip_addr_i,
		wdata:  bus2ip_data_i
	};

	bus_decode u_decode (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.arst_n_i     (arst_n_i),
		.req_i        (bus_req),
		.rdce_i       (bus2ip_rdce_i),
		.wrce_i       (bus2ip_wrce_i),
		.ctrl_rdata_i (ctrl_rdata),
		.other_rdata_i(other_rdata),
		.s_rdata_i    (s_rdata),
		.ctrl_req_o   (ctrl_req),
		.other_req_o  (other_req),
		.s_req_o      (s_req),
		.rdata_o      (ip2bus_data_o),
		.rdack_o      (ip2bus_rdack_o),
		.wrack_o      (ip2bus_wrack_o)
	);

	// start bits double as the per-bank running flags
	job_control u_job (
		.Bus2IP_Clk  (Bus2IP_Clk),
		.arst_n_i    (arst_n_i),
		.req_i       (ctrl_req),
		.core_done_i (core_done_i),
		.rdata_o     (ctrl_rdata),
		.core_start_o(core_start_o)
	);

	for (genvar c = 0; c < num_cores; c++) begin : g_bank
		core_mem_bank u_bank (
			.Bus2IP_Clk   (Bus2IP_Clk),
			.running_i    (core_start_o[c]),
			.other_req_i  (other_req[c]),
			.s_req_i      (s_req[c]),
			.other_rdata_o(other_rdata[c]),
			.s_rdata_o    (s_rdata[c])
		);
	end

endmodule

`default_nettype wire

/* testbench/tb_tasks.svh */
// lfsr random source, address builder, bus write and read tasks, checks and test summary
`ifndef tb_tasks_svh
`define tb_tasks_svh
`default_nettype none

// fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

// byte address whose core field position depends on the region
function automatic logic [31:0] addr_of(input region_e rgn, input int core, input int word);
	logic [31:0] a;
	case (rgn)
		region_other: a = (core << 8) | (word << 2);
		region_s:     a = (core << 12) | (word << 2);
		default:      a = word << 2;
	endcase
	return a;
endfunction

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
		errors++;
	end
endtask

// wrack comes with wrce and the write lands on the edge that drops it
task automatic bus_write(input region_e rgn, input logic [31:0] a, input logic [31:0] d);
	int waited;
	waited = 0;
	@(posedge Bus2IP_Clk);
	cs <= rgn;
	rnw <= 1'b0;
	addr <= a;
	wdata <= d;
	wrce <= 1'b1;
	@(negedge Bus2IP_Clk);
	while (!wrack && waited < 8) begin
		@(negedge Bus2IP_Clk);
		waited++;
	end
	if (!wrack) begin
		$display("no write acknowledge for address %08h", a);
		errors++;
	end else if (waited != 0) begin
		$display("write acknowledge came %0d cycles after wrce, expected 0", waited);
		errors++;
	end
	@(posedge Bus2IP_Clk);
	wrce <= 1'b0;
	rnw <= 1'b1;
endtask

// rdack expected on the cycle after rdce rises with the data
task automatic read_check(input string name, input region_e rgn, input logic [31:0] a,
	input logic [31:0] exp);
	int cycles;
	cycles = 0;
	@(posedge Bus2IP_Clk);
	cs <= rgn;
	rnw <= 1'b1;
	addr <= a;
	rdce <= 1'b1;
	@(negedge Bus2IP_Clk);
	while (!rdack && cycles < 8) begin
		@(negedge Bus2IP_Clk);
		cycles++;
	end
	if (!rdack) begin
		$display("%s: no read acknowledge for address %08h", name, a);
		errors++;
	end else begin
		if (cycles != 1) begin
			$display("%s: read acknowledge came %0d cycles after rdce, expected 1", name, cycles);
			errors++;
		end
		check_word(name, exp, rdata);
	end
	@(posedge Bus2IP_Clk);
	rdce <= 1'b0;
endtask

// poll until the masked start bits are all low
task automatic wait_start_low(input logic [num_cores-1:0] mask, input int limit);
	int n;
	n = 0;
	@(negedge Bus2IP_Clk);
	while ((core_start & mask) != '0 && n < limit) begin
		@(negedge Bus2IP_Clk);
		n++;
	end
	if ((core_start & mask) != '0) begin
		$display("start bits %b still high after %0d cycles", core_start, limit);
		errors++;
	end
endtask

task automatic end_test(input string name, input int err_before);
	tests_run++;
	if (errors == err_before) begin
		$display("test %s: pass", name);
	end else begin
		tests_failed++;
		$display("test %s: FAIL, %0d errors", name, errors - err_before);
	end
endtask

`default_nettype wire
`endif

/* testbench/tb_top.sv */
// clock, reset, dut, engine and memory models, start monitor, tests and watchdog
`default_nettype none
`timescale 1ns/10ps

module tb_top;

	import bcrypt_host_pkg::*;

	// watchdog budget from the worst engine delay plus bus traffic per test
	localparam int num_tests = 5;
	localparam int max_delay = 40;
	localparam int bus_cycles = 500;
	localparam int watchdog_cycles = 4 * (8 + num_tests * (max_delay + bus_cycles));

	logic                  Bus2IP_Clk = 1'b0;
	logic                  arst_n;
	region_e               cs;
	logic                  rnw;
	logic [31:0]           addr;
	logic [data_width-1:0] wdata;
	logic                  rdce;
	logic                  wrce;
	logic [data_width-1:0] rdata;
	logic                  rdack;
	logic                  wrack;
	logic [num_cores-1:0]  core_start;
	logic [num_cores-1:0]  core_done = '0;
	logic [15:0]           lfsr = 16'd43828;
	// memory model of both memories of every core
	logic [data_width-1:0] model_other [num_cores][other_depth];
	logic [data_width-1:0] model_s [num_cores][s_depth];
	// engine model state
	int                    eng_delay [num_cores];
	int                    eng_cnt [num_cores];
	logic [num_cores-1:0]  eng_sent = '0;
	// edges since each done pulse for the start monitor
	int                    age [num_cores];
	logic                  mon_on = 1'b0;
	int                    errors = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;
	int                    err0;
	int                    c;
	int                    w;
	int                    fast;
	int                    slow;
	logic [31:0]           d;
	logic [num_cores-1:0]  fast_mask;
	int                    cq [$];
	int                    wq [$];

	always #50 Bus2IP_Clk = ~Bus2IP_Clk;

	bcrypt_host_top uut (
		.Bus2IP_Clk    (Bus2IP_Clk),
		.arst_n_i      (arst_n),
		.bus2ip_cs_i   (cs),
		.bus2ip_rnw_i  (rnw),
		.bus2ip_addr_i (addr),
		.bus2ip_data_i (wdata),
		.bus2ip_rdce_i (rdce),
		.bus2ip_wrce_i (wrce),
		.ip2bus_data_o (rdata),
		.ip2bus_rdack_o(rdack),
		.ip2bus_wrack_o(wrack),
		.core_start_o  (core_start),
		.core_done_i   (core_done)
	);

	// engine model pulses done once per core per run after its delay
	always @(posedge Bus2IP_Clk) begin
		for (int k = 0; k < num_cores; k++) begin
			core_done[k] <= 1'b0;
			if (core_start[k] && !eng_sent[k]) begin
				if (eng_cnt[k] >= eng_delay[k] - 1) begin
					core_done[k] <= 1'b1;
					eng_sent[k] <= 1'b1;
				end else begin
					eng_cnt[k] <= eng_cnt[k] + 1;
				end
			end
			// all idle so ready for the next run
			if (core_start == '0) begin
				eng_sent[k] <= 1'b0;
				eng_cnt[k] <= 0;
			end
		end
	end

	// start bit stays high until two edges past its sampled done pulse
	always @(negedge Bus2IP_Clk) begin
		for (int k = 0; k < num_cores; k++) begin
			if (!mon_on) begin
				age[k] = 0;
			end else begin
				if (core_start[k] !== (age[k] < 2)) begin
					$display("Mismatch run_start core %0d: expected %0d, actual %0d",
						k, age[k] < 2, core_start[k]);
					errors++;
				end
				if (age[k] > 0) begin
					age[k]++;
				end
				if (core_done[k]) begin
					age[k] = 1;
				end
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge Bus2IP_Clk);
		$display("watchdog expired after %0d cycles, tests did not complete", watchdog_cycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		arst_n <= 1'b0;
		cs <= region_ctrl;
		rnw <= 1'b1;
		addr <= '0;
		wdata <= '0;
		rdce <= 1'b0;
		wrce <= 1'b0;
		repeat (8) @(posedge Bus2IP_Clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge Bus2IP_Clk);

		// reset state with nothing written yet
		err0 = errors;
		@(negedge Bus2IP_Clk);
		check_word("reset_state start", 32'h0, 32'(core_start));
		read_check("reset_state ctrl0", region_ctrl, addr_of(region_ctrl, 0, 0), 32'h0);
		read_check("reset_state ctrl1", region_ctrl, addr_of(region_ctrl, 0, 1), 32'h0);
		end_test("reset_state", err0);

		// random words into both regions of random idle cores
		err0 = errors;
		for (int i = 0; i < 24; i++) begin
			c = int'(rand_bits(2));
			w = int'(rand_bits(6));
			d = rand_bits(32);
			model_other[c][w] = d;
			bus_write(region_other, addr_of(region_other, c, w), d);
			d = rand_bits(32);
			model_s[c][w] = d;
			bus_write(region_s, addr_of(region_s, c, w), d);
			read_check("mem_rw other", region_other, addr_of(region_other, c, w),
				model_other[c][w]);
			read_check("mem_rw s", region_s, addr_of(region_s, c, w), model_s[c][w]);
			cq.push_back(c);
			wq.push_back(w);
		end
		// second pass checks that later writes left earlier words alone
		foreach (cq[k]) begin
			read_check("mem_rw other again", region_other, addr_of(region_other, cq[k], wq[k]),
				model_other[cq[k]][wq[k]]);
			read_check("mem_rw s again", region_s, addr_of(region_s, cq[k], wq[k]),
				model_s[cq[k]][wq[k]]);
		end
		end_test("mem_rw", err0);

		// run command raises the start bits one cycle later and each drops after its done
		err0 = errors;
		for (int k = 0; k < num_cores; k++) begin
			eng_delay[k] = 5 + int'(rand_bits(6)) % 36;
		end
		bus_write(region_ctrl, addr_of(region_ctrl, 0, 0), cmd_run);
		@(negedge Bus2IP_Clk);
		check_word("run_start before", 32'h0, 32'(core_start));
		@(negedge Bus2IP_Clk);
		check_word("run_start rise", 32'((1 << num_cores) - 1), 32'(core_start));
		mon_on = 1'b1;
		wait_start_low('1, 2 * max_delay);
		mon_on = 1'b0;
		end_test("run_start", err0);

		// completion status that a host write to word 0 clears
		err0 = errors;
		read_check("run_finish ctrl0", region_ctrl, addr_of(region_ctrl, 0, 0), cmd_idle);
		read_check("run_finish ctrl1", region_ctrl, addr_of(region_ctrl, 0, 1), 32'hFF);
		// start bits stay low once word 0 is idle
		@(negedge Bus2IP_Clk);
		check_word("run_finish start", 32'h0, 32'(core_start));
		bus_write(region_ctrl, addr_of(region_ctrl, 0, 0), cmd_idle);
		read_check("run_finish ctrl1 clear", region_ctrl, addr_of(region_ctrl, 0, 1), 32'h0);
		end_test("run_finish", err0);

		// one fast core while the rest run long enough to block writes
		err0 = errors;
		fast = int'(rand_bits(2));
		slow = (fast + 1 + int'(rand_bits(1))) % num_cores;
		w = int'(rand_bits(6));
		d = rand_bits(32);
		model_other[slow][w] = d;
		bus_write(region_other, addr_of(region_other, slow, w), d);
		d = rand_bits(32);
		model_s[slow][w] = d;
		bus_write(region_s, addr_of(region_s, slow, w), d);
		for (int k = 0; k < num_cores; k++) begin
			eng_delay[k] = 32 + int'(rand_bits(3));
		end
		eng_delay[fast] = 5 + int'(rand_bits(2));
		fast_mask = '0;
		fast_mask[fast] = 1'b1;
		bus_write(region_ctrl, addr_of(region_ctrl, 0, 0), cmd_run);
		repeat (2) @(negedge Bus2IP_Clk);
		mon_on = 1'b1;
		wait_start_low(fast_mask, 2 * max_delay);
		if (!core_start[slow]) begin
			$display("run_block: core %0d finished before the blocked writes", slow);
			errors++;
		end
		// writes to the running core are acknowledged but dropped
		bus_write(region_other, addr_of(region_other, slow, w), rand_bits(32));
		bus_write(region_s, addr_of(region_s, slow, w), rand_bits(32));
		// finished core takes writes again
		d = rand_bits(32);
		model_other[fast][w] = d;
		bus_write(region_other, addr_of(region_other, fast, w), d);
		read_check("run_block other running", region_other, addr_of(region_other, slow, w),
			model_other[slow][w]);
		wait_start_low('1, 2 * max_delay);
		mon_on = 1'b0;
		read_check("run_block s", region_s, addr_of(region_s, slow, w), model_s[slow][w]);
		read_check("run_block other idle", region_other, addr_of(region_other, fast, w),
			model_other[fast][w]);
		end_test("run_block", err0);

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	`include "tb_tasks.svh"

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
hdl/bcrypt_host_pkg.sv
hdl/word_ram.sv
hdl/core_mem_bank.sv
hdl/job_control.sv
hdl/bus_decode.sv
hdl/bcrypt_host_top.sv
testbench/tb_top.sv

/* Makefile */
# Verilator build and run of the bcrypt host controller testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_top -o Vtb_top

run: compile
	./obj_dir/Vtb_top | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
